// File: calendar_pkg.sv
package calendar_pkg;

	typedef logic [3:0]  bcd_digit_t; // one decimal digit
	typedef logic [7:0]  bcd_pair_t;  // two digits, tens in the upper nibble
	typedef logic [15:0] bcd_year_t;  // four year digits, thousands first

	// code outside 0..9, shown with all segments dark
	localparam bcd_digit_t bcd_blank = 4'hf;

	typedef struct packed {
		bcd_digit_t hour_tens;
		bcd_digit_t hour_ones;
		bcd_digit_t min_tens;
		bcd_digit_t min_ones;
		bcd_digit_t sec_tens;
		bcd_digit_t sec_ones;
	} tod_t;

	typedef struct packed {
		bcd_digit_t day_tens;
		bcd_digit_t day_ones;
		bcd_digit_t month_tens;
		bcd_digit_t month_ones;
		bcd_digit_t year_thou;
		bcd_digit_t year_hund;
		bcd_digit_t year_tens;
		bcd_digit_t year_ones;
	} date_t;

	localparam tod_t reset_tod = '{
		hour_tens: 4'd0, hour_ones: 4'd0,
		min_tens:  4'd0, min_ones:  4'd0,
		sec_tens:  4'd0, sec_ones:  4'd0
	}; // 00:00:00

	localparam date_t reset_date = '{
		day_tens:   4'd0, day_ones:   4'd1,
		month_tens: 4'd0, month_ones: 4'd1,
		year_thou:  4'd2, year_hund:  4'd0,
		year_tens:  4'd0, year_ones:  4'd0
	}; // 01-01-2000

endpackage

// File: adjust_pkg.sv
package adjust_pkg;

	typedef logic [31:0] reg_data_t;

	typedef enum logic [2:0] {
		ctrl      = 3'd0, // run and show_time flags
		load_time = 3'd1, // data[23:0] is a tod_t
		load_date = 3'd2, // data[31:0] is a date_t
		step_day  = 3'd3  // one day forward, only while stopped
	} reg_addr_t;

	// bit positions inside the ctrl register
	localparam int ctrl_run_bit       = 0;
	localparam int ctrl_show_time_bit = 1;

	typedef struct packed {
		logic      valid;
		reg_addr_t addr;
		reg_data_t data;
	} wr_req_t;

	// bit 6 is segment a, bit 0 is segment g, 1 means lit
	typedef logic [6:0] seg_t;

endpackage

// File: time_of_day_counter.sv
module time_of_day_counter (
	input  logic               intermediate_clk,
	input  logic               rst_calendar,
	input  logic               tick,
	input  logic               load,
	input  calendar_pkg::tod_t load_value,
	output calendar_pkg::tod_t tod,
	output logic               midnight
);

	logic               sec_ones_max;
	logic               sec_max;
	logic               min_ones_max;
	logic               min_max;
	logic               hour_max;
	logic               day_wrap;
	calendar_pkg::tod_t next_tod;

	assign sec_ones_max = (tod.sec_ones == 4'd9);
	assign sec_max      = sec_ones_max && (tod.sec_tens == 4'd5); // xx:xx:59
	assign min_ones_max = (tod.min_ones == 4'd9);
	assign min_max      = min_ones_max && (tod.min_tens == 4'd5); // xx:59:xx
	assign hour_max     = (tod.hour_tens == 4'd2) && (tod.hour_ones == 4'd3);
	assign day_wrap     = sec_max && min_max && hour_max; // 23:59:59

	// cascaded increment, each digit rolls only when all lower ones are at max
	always_comb begin
		next_tod = tod;
		if (!sec_ones_max) begin
			next_tod.sec_ones = tod.sec_ones + 4'd1;
		end else begin
			next_tod.sec_ones = 4'd0;
			if (!sec_max) begin
				next_tod.sec_tens = tod.sec_tens + 4'd1;
			end else begin
				next_tod.sec_tens = 4'd0;
				if (!min_ones_max) begin
					next_tod.min_ones = tod.min_ones + 4'd1;
				end else begin
					next_tod.min_ones = 4'd0;
					if (!min_max) begin
						next_tod.min_tens = tod.min_tens + 4'd1;
					end else begin
						next_tod.min_tens = 4'd0;
						if (hour_max) begin
							next_tod.hour_tens = 4'd0; // 23 -> 00
							next_tod.hour_ones = 4'd0;
						end else if (tod.hour_ones == 4'd9) begin
							next_tod.hour_tens = tod.hour_tens + 4'd1;
							next_tod.hour_ones = 4'd0;
						end else begin
							next_tod.hour_ones = tod.hour_ones + 4'd1;
						end
					end
				end
			end
		end
	end

	always_ff @(posedge intermediate_clk or negedge rst_calendar) begin
		if (!rst_calendar) begin
			tod      <= calendar_pkg::reset_tod;
			midnight <= 1'b0;
		end else begin
			midnight <= 1'b0;
			if (load) begin
				tod <= load_value; // load wins over a tick
			end else if (tick) begin
				tod      <= next_tod;
				midnight <= day_wrap;
			end
		end
	end

endmodule

// File: calendar_counter.sv
module calendar_counter (
	input  logic                intermediate_clk,
	input  logic                rst_calendar,
	input  logic                advance_day,
	input  logic                step_day,
	input  logic                load,
	input  calendar_pkg::date_t load_value,
	output calendar_pkg::date_t date
);

	logic                    advance;
	logic                    century;
	logic                    leap_year;
	calendar_pkg::bcd_pair_t day_bcd;
	calendar_pkg::bcd_pair_t month_bcd;
	calendar_pkg::bcd_pair_t last_day;
	calendar_pkg::bcd_year_t year_bcd;
	calendar_pkg::date_t     next_date;

	// 10*t + o is a multiple of 4 when o is 0/4/8 for even t, 2/6 for odd t
	function automatic logic bcd_div4(
		input calendar_pkg::bcd_digit_t tens,
		input calendar_pkg::bcd_digit_t ones
	);
		if (tens[0]) begin
			return (ones == 4'd2) || (ones == 4'd6);
		end
		return (ones == 4'd0) || (ones == 4'd4) || (ones == 4'd8);
	endfunction

	function automatic calendar_pkg::bcd_year_t bcd_year_inc(
		input calendar_pkg::bcd_year_t year
	);
		calendar_pkg::bcd_year_t result;
		logic                    carry;
		result = year;
		carry  = 1'b1;
		for (int i = 0; i < 4; i++) begin
			if (carry) begin
				if (year[i*4 +: 4] == 4'd9) begin
					result[i*4 +: 4] = 4'd0; // keep carrying, 9999 ends at 0000
				end else begin
					result[i*4 +: 4] = year[i*4 +: 4] + 4'd1;
					carry            = 1'b0;
				end
			end
		end
		return result;
	endfunction

	assign advance   = advance_day | step_day; // both at once still count one day
	assign day_bcd   = {date.day_tens, date.day_ones};
	assign month_bcd = {date.month_tens, date.month_ones};
	assign year_bcd  = {date.year_thou, date.year_hund, date.year_tens, date.year_ones};

	// gregorian rule, century years use the upper two digits
	assign century   = (date.year_tens == 4'd0) && (date.year_ones == 4'd0);
	assign leap_year = century ? bcd_div4(date.year_thou, date.year_hund)
		: bcd_div4(date.year_tens, date.year_ones);

	always_comb begin
		case (month_bcd)
			8'h04, 8'h06, 8'h09, 8'h11: last_day = 8'h30;
			8'h02:                      last_day = leap_year ? 8'h29 : 8'h28;
			default:                    last_day = 8'h31;
		endcase
	end

	always_comb begin
		next_date = date;
		if (day_bcd != last_day) begin
			if (date.day_ones == 4'd9) begin
				next_date.day_tens = date.day_tens + 4'd1;
				next_date.day_ones = 4'd0;
			end else begin
				next_date.day_ones = date.day_ones + 4'd1;
			end
		end else begin
			next_date.day_tens = 4'd0; // first of next month
			next_date.day_ones = 4'd1;
			if (month_bcd == 8'h12) begin
				next_date.month_tens = 4'd0;
				next_date.month_ones = 4'd1;
				{next_date.year_thou, next_date.year_hund,
					next_date.year_tens, next_date.year_ones} = bcd_year_inc(year_bcd);
			end else if (date.month_ones == 4'd9) begin
				next_date.month_tens = 4'd1; // september -> october
				next_date.month_ones = 4'd0;
			end else begin
				next_date.month_ones = date.month_ones + 4'd1;
			end
		end
	end

	always_ff @(posedge intermediate_clk or negedge rst_calendar) begin
		if (!rst_calendar) begin
			date <= calendar_pkg::reset_date;
		end else if (load) begin
			date <= load_value;
		end else if (advance) begin
			date <= next_date;
		end
	end

endmodule

// File: adjust_regs.sv
module adjust_regs (
	input  logic                intermediate_clk,
	input  logic                rst_calendar,
	input  adjust_pkg::wr_req_t wr,
	input  logic                second_tick,
	output logic                run_tick,
	output logic                tod_load,
	output calendar_pkg::tod_t  tod_value,
	output logic                date_load,
	output calendar_pkg::date_t date_value,
	output logic                day_step,
	output logic                show_time
);

	logic run;

	assign run_tick = second_tick & run; // stopped clock ignores ticks

	always_ff @(posedge intermediate_clk or negedge rst_calendar) begin
		if (!rst_calendar) begin
			run       <= 1'b1;
			show_time <= 1'b0;
			tod_load  <= 1'b0;
			date_load <= 1'b0;
			day_step  <= 1'b0;
		end else begin
			tod_load  <= 1'b0; // strobes last one cycle
			date_load <= 1'b0;
			day_step  <= 1'b0;
			if (wr.valid) begin
				case (wr.addr)
					adjust_pkg::ctrl: begin
						run       <= wr.data[adjust_pkg::ctrl_run_bit];
						show_time <= wr.data[adjust_pkg::ctrl_show_time_bit];
					end
					adjust_pkg::load_time: begin
						tod_load <= 1'b1;
					end
					adjust_pkg::load_date: begin
						date_load <= 1'b1;
					end
					adjust_pkg::step_day: begin
						day_step <= !run; // manual stepping only while stopped
					end
					default: begin
						// unmapped address, write dropped
					end
				endcase
			end
		end
	end

	// load values captured alongside the strobe
	always_ff @(posedge intermediate_clk) begin
		if (wr.valid && (wr.addr == adjust_pkg::load_time)) begin
			tod_value <= wr.data[$bits(calendar_pkg::tod_t)-1:0];
		end
		if (wr.valid && (wr.addr == adjust_pkg::load_date)) begin
			date_value <= wr.data;
		end
	end

endmodule

// File: segment_display.sv
module segment_display #(
	parameter bit SEG_ACTIVE_LOW = 1'b1
) (
	input  logic                intermediate_clk,
	input  logic                rst_calendar,
	input  calendar_pkg::tod_t  tod,
	input  calendar_pkg::date_t date,
	input  logic                show_time,
	output adjust_pkg::seg_t    segs [8]
);

	localparam adjust_pkg::seg_t seg_off = SEG_ACTIVE_LOW ? 7'h7f : 7'h00;

	calendar_pkg::bcd_digit_t digits [8];

	function automatic adjust_pkg::seg_t encode(input calendar_pkg::bcd_digit_t d);
		case (d)
			4'd0:    return 7'b1111110;
			4'd1:    return 7'b0110000;
			4'd2:    return 7'b1101101;
			4'd3:    return 7'b1111001;
			4'd4:    return 7'b0110011;
			4'd5:    return 7'b1011011;
			4'd6:    return 7'b1011111;
			4'd7:    return 7'b1110000;
			4'd8:    return 7'b1111111;
			4'd9:    return 7'b1111011;
			default: return 7'b0000000; // blank and non-bcd codes
		endcase
	endfunction

	// digit 0 is the left-most position
	always_comb begin
		if (show_time) begin
			digits[0] = tod.hour_tens;
			digits[1] = tod.hour_ones;
			digits[2] = tod.min_tens;
			digits[3] = tod.min_ones;
			digits[4] = tod.sec_tens;
			digits[5] = tod.sec_ones;
			digits[6] = calendar_pkg::bcd_blank;
			digits[7] = calendar_pkg::bcd_blank;
		end else begin
			digits[0] = date.day_tens; // DDMMYYYY
			digits[1] = date.day_ones;
			digits[2] = date.month_tens;
			digits[3] = date.month_ones;
			digits[4] = date.year_thou;
			digits[5] = date.year_hund;
			digits[6] = date.year_tens;
			digits[7] = date.year_ones;
		end
	end

	always_ff @(posedge intermediate_clk or negedge rst_calendar) begin
		if (!rst_calendar) begin
			for (int i = 0; i < 8; i++) begin
				segs[i] <= seg_off; // dark while in reset
			end
		end else begin
			for (int i = 0; i < 8; i++) begin
				segs[i] <= SEG_ACTIVE_LOW ? ~encode(digits[i]) : encode(digits[i]);
			end
		end
	end

endmodule

// File: clock_calendar_top.sv
module clock_calendar_top #(
	parameter bit SEG_ACTIVE_LOW = 1'b1
) (
	input  logic                intermediate_clk,
	input  logic                rst_calendar,
	input  logic                second_tick,
	input  adjust_pkg::wr_req_t wr,
	output calendar_pkg::tod_t  tod,
	output calendar_pkg::date_t date,
	output adjust_pkg::seg_t    segs [8]
);

	logic                run_tick;
	logic                tod_load;
	calendar_pkg::tod_t  tod_value;
	logic                date_load;
	calendar_pkg::date_t date_value;
	logic                day_step;
	logic                show_time;
	logic                midnight;

	adjust_regs adjust_regs_i (
		.intermediate_clk (intermediate_clk),
		.rst_calendar     (rst_calendar),
		.wr               (wr),
		.second_tick      (second_tick),
		.run_tick         (run_tick),
		.tod_load         (tod_load),
		.tod_value        (tod_value),
		.date_load        (date_load),
		.date_value       (date_value),
		.day_step         (day_step),
		.show_time        (show_time)
	);

	time_of_day_counter time_of_day_counter_i (
		.intermediate_clk (intermediate_clk),
		.rst_calendar     (rst_calendar),
		.tick             (run_tick),
		.load             (tod_load),
		.load_value       (tod_value),
		.tod              (tod),
		.midnight         (midnight)
	);

	calendar_counter calendar_counter_i (
		.intermediate_clk (intermediate_clk),
		.rst_calendar     (rst_calendar),
		.advance_day      (midnight), // rollover from the time counter
		.step_day         (day_step),
		.load             (date_load),
		.load_value       (date_value),
		.date             (date)
	);

	segment_display #(
		.SEG_ACTIVE_LOW (SEG_ACTIVE_LOW)
	) segment_display_i (
		.intermediate_clk (intermediate_clk),
		.rst_calendar     (rst_calendar),
		.tod              (tod),
		.date             (date),
		.show_time        (show_time),
		.segs             (segs)
	);

endmodule

// File: tb_clock_calendar.sv
module tb_clock_calendar;

	localparam int n_writes        = 43;
	localparam int n_random_ticks  = 40;
	localparam int n_ticks         = n_random_ticks + 4;
	localparam int max_gap         = 5;
	// reset, three cycles per write, worst case per tick, then a margin
	localparam int watchdog_cycles = 5 + 3 * n_writes + (max_gap + 1) * n_ticks + 100;

	// patterns a..g with 1 meaning lit, indexed by the digit
	localparam adjust_pkg::seg_t seg_table [10] = '{
		7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f, 7'h70, 7'h7f, 7'h7b
	};
	localparam int          feb_years [4]      = '{2024, 2023, 1900, 2000};
	localparam logic [31:0] feb_after_28th [4] = '{
		32'h29022024, 32'h01032023, 32'h01031900, 32'h29022000
	};

	logic                intermediate_clk;
	logic                rst_calendar;
	logic                second_tick;
	adjust_pkg::wr_req_t wr;
	calendar_pkg::tod_t  tod;
	calendar_pkg::date_t date;
	adjust_pkg::seg_t    segs [8];

	int                  errors = 0;
	int                  checks = 0;
	int                  m_secs; // model time, seconds since midnight
	int                  m_day;
	int                  m_month;
	int                  m_year;
	logic                m_run;
	logic                m_show;
	logic                pend_tod_load;
	int                  pend_tod_secs;
	logic                pend_date_load;
	logic [31:0]         pend_date;
	logic                pend_step;
	logic                pend_mid;
	adjust_pkg::seg_t    exp_segs [8];

	clock_calendar_top #(
		.SEG_ACTIVE_LOW (1'b1)
	) clock_calendar_top_i (
		.intermediate_clk (intermediate_clk),
		.rst_calendar     (rst_calendar),
		.second_tick      (second_tick),
		.wr               (wr),
		.tod              (tod),
		.date             (date),
		.segs             (segs)
	);

	initial intermediate_clk = 1'b0;
	always #4 intermediate_clk = ~intermediate_clk;

	function automatic int dec2(input logic [3:0] tens, input logic [3:0] ones);
		return int'(tens) * 10 + int'(ones);
	endfunction

	function automatic int secs_of(input logic [23:0] v);
		return dec2(v[23:20], v[19:16]) * 3600 + dec2(v[15:12], v[11:8]) * 60
			+ dec2(v[7:4], v[3:0]);
	endfunction

	function automatic calendar_pkg::tod_t tod_bcd(input int secs);
		int h;
		int m;
		int s;
		h = secs / 3600;
		m = (secs / 60) % 60;
		s = secs % 60;
		return {4'(h / 10), 4'(h % 10), 4'(m / 10), 4'(m % 10), 4'(s / 10), 4'(s % 10)};
	endfunction

	function automatic calendar_pkg::date_t date_bcd(input int d, input int mo, input int y);
		return {4'(d / 10), 4'(d % 10), 4'(mo / 10), 4'(mo % 10),
			4'(y / 1000), 4'((y / 100) % 10), 4'((y / 10) % 10), 4'(y % 10)};
	endfunction

	function automatic int month_days(input int month, input int year);
		bit leap;
		leap = ((year % 4 == 0) && (year % 100 != 0)) || (year % 400 == 0);
		case (month)
			2:           return leap ? 29 : 28;
			4, 6, 9, 11: return 30;
			default:     return 31;
		endcase
	endfunction

	function automatic adjust_pkg::seg_t seg_for(input calendar_pkg::bcd_digit_t digit);
		if (digit > 4'd9) begin
			return 7'h7f; // blank, all dark
		end
		return ~seg_table[digit];
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] want,
		input logic [31:0] got);
		errors++;
		$display("Mismatch at %0t: %s expected %h actual %h", $time, name, want, got);
	endtask

	task automatic reset_model();
		m_secs         = 0;
		m_day          = 1;
		m_month        = 1;
		m_year         = 2000;
		m_run          = 1'b1;
		m_show         = 1'b0;
		pend_tod_load  = 1'b0;
		pend_date_load = 1'b0;
		pend_step      = 1'b0;
		pend_mid       = 1'b0;
		for (int i = 0; i < 8; i++) begin
			exp_segs[i] = 7'h7f;
		end
	endtask

	task automatic advance_model_day();
		m_day++;
		if (m_day > month_days(m_month, m_year)) begin
			m_day = 1;
			m_month++;
			if (m_month > 12) begin
				m_month = 1;
				m_year  = (m_year + 1) % 10000; // 9999 wraps to 0000
			end
		end
	endtask

	task automatic fill_expected_segs();
		logic [31:0] digits;
		digits = m_show ? {tod_bcd(m_secs), 8'hff} : {date_bcd(m_day, m_month, m_year)};
		for (int i = 0; i < 8; i++) begin
			exp_segs[i] = seg_for(digits[31 - 4 * i -: 4]);
		end
	endtask

	// cycle model of the register, counter and display timing
	always @(posedge intermediate_clk or negedge rst_calendar) begin
		if (!rst_calendar) begin
			reset_model();
		end else begin
			fill_expected_segs(); // display shows last cycle's state
			if (pend_date_load) begin
				m_day   = dec2(pend_date[31:28], pend_date[27:24]);
				m_month = dec2(pend_date[23:20], pend_date[19:16]);
				m_year  = dec2(pend_date[15:12], pend_date[11:8]) * 100
					+ dec2(pend_date[7:4], pend_date[3:0]);
			end else if (pend_step || pend_mid) begin
				advance_model_day(); // one day even when both
			end
			pend_mid = 1'b0;
			if (pend_tod_load) begin
				m_secs = pend_tod_secs;
			end else if (second_tick && m_run) begin
				pend_mid = (m_secs == 86399);
				m_secs   = (m_secs + 1) % 86400;
			end
			pend_tod_load  = wr.valid && (wr.addr == adjust_pkg::load_time);
			pend_tod_secs  = secs_of(wr.data[23:0]);
			pend_date_load = wr.valid && (wr.addr == adjust_pkg::load_date);
			pend_date      = wr.data;
			pend_step      = wr.valid && (wr.addr == adjust_pkg::step_day) && !m_run;
			if (wr.valid && (wr.addr == adjust_pkg::ctrl)) begin
				m_run  = wr.data[0];
				m_show = wr.data[1];
			end
		end
	end

	// outputs settle well before the falling edge
	always @(negedge intermediate_clk) begin
		if (rst_calendar) begin
			checks += 10;
			assert (tod == tod_bcd(m_secs))
				else report_mismatch("tod", {8'h0, tod_bcd(m_secs)}, {8'h0, tod});
			assert (date == date_bcd(m_day, m_month, m_year))
				else report_mismatch("date", date_bcd(m_day, m_month, m_year), date);
			for (int i = 0; i < 8; i++) begin
				assert (segs[i] == exp_segs[i]) else report_mismatch(
					$sformatf("segs[%0d]", i), {25'h0, exp_segs[i]}, {25'h0, segs[i]});
			end
		end
	end

	task automatic next_cycle();
		@(posedge intermediate_clk);
		#1;
	endtask

	// write, strobe cycle, counter update
	task automatic write_reg(input adjust_pkg::reg_addr_t addr, input logic [31:0] data);
		wr.valid = 1'b1;
		wr.addr  = addr;
		wr.data  = data;
		next_cycle();
		wr.valid = 1'b0;
		repeat (2) next_cycle();
	endtask

	task automatic send_tick();
		second_tick = 1'b1;
		next_cycle();
		second_tick = 1'b0;
	endtask

	task automatic load_and_step(input int d, input int mo, input int y);
		write_reg(adjust_pkg::load_date, date_bcd(d, mo, y));
		write_reg(adjust_pkg::step_day, 32'h0);
	endtask

	task automatic expect_date(input logic [31:0] want);
		checks++;
		assert (date == want) else report_mismatch("date", want, date);
	endtask

	task automatic expect_tod(input logic [23:0] want);
		checks++;
		assert (tod == want) else report_mismatch("tod", {8'h0, want}, {8'h0, tod});
	endtask

	initial begin
		int unsigned gap;
		rst_calendar = 1'b0;
		second_tick  = 1'b0;
		wr           = '0;
		void'($urandom(32'h18a14016));
		repeat (5) @(posedge intermediate_clk);
		#1;
		rst_calendar = 1'b1;
		next_cycle();
		expect_date(calendar_pkg::reset_date);
		expect_tod(calendar_pkg::reset_tod);

		write_reg(adjust_pkg::load_time, 32'h00235959);
		send_tick();
		expect_tod(24'h000000);
		expect_date(calendar_pkg::reset_date); // midnight still in flight
		next_cycle();
		expect_date(32'h02012000);

		write_reg(adjust_pkg::ctrl, 32'h0); // stop, stepping allowed
		for (int mo = 1; mo <= 12; mo++) begin
			if (mo != 2) begin
				load_and_step(month_days(mo, 2001), mo, 2001);
			end
		end
		for (int k = 0; k < 4; k++) begin
			load_and_step(28, 2, feb_years[k]);
			expect_date(feb_after_28th[k]);
			if (feb_after_28th[k][31:24] == 8'h29) begin
				load_and_step(29, 2, feb_years[k]);
			end
		end
		load_and_step(31, 12, 9999);
		expect_date(32'h01010000);

		repeat (3) send_tick();
		expect_tod(24'h000000); // stopped clock holds midnight
		write_reg(adjust_pkg::step_day, 32'h0);
		expect_date(32'h02010000);
		write_reg(adjust_pkg::ctrl, 32'h1);
		write_reg(adjust_pkg::step_day, 32'h0);
		expect_date(32'h02010000);

		write_reg(adjust_pkg::load_time, 32'h00235930);
		write_reg(adjust_pkg::ctrl, 32'h3);
		for (int k = 6; k < 8; k++) begin
			checks++;
			assert (segs[k] == 7'h7f) else report_mismatch(
				$sformatf("segs[%0d]", k), 32'h7f, {25'h0, segs[k]});
		end
		for (int n = 0; n < n_random_ticks; n++) begin
			send_tick();
			gap = $urandom_range(max_gap);
			repeat (gap) next_cycle();
		end
		repeat (3) next_cycle();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		#(watchdog_cycles * 8);
		$display("Watchdog expired after %0d cycles, the test sequence did not finish",
			watchdog_cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: files.f
calendar_pkg.sv
adjust_pkg.sv
time_of_day_counter.sv
calendar_counter.sv
adjust_regs.sv
segment_display.sv
clock_calendar_top.sv
tb_clock_calendar.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_clock_calendar -f files.f -o sim_clock_calendar
output=$(./obj_dir/sim_clock_calendar)
echo "$output"
if grep -qF "*** TEST PASSED ***" <<< "$output"; then
	exit 0
fi
exit 1
